// ==== common/lj_pkg.sv ====
// Shared widths, pair and force structs and the force coefficient rule; imported by the LJ pipeline and its testbench
`default_nettype none

package lj_pkg;

	// Word formats
	localparam int DATA_WIDTH        = 32;  // Q16.16 coordinates, r2, coefficients, forces
	localparam int FRAC_BITS         = 16;
	localparam int PARTICLE_ID_WIDTH = 21;  // Three 4-bit cell IDs + 9-bit in-cell address

	// Force table geometry
	localparam int SEGMENT_NUM   = 14;
	localparam int SEGMENT_WIDTH = 4;
	localparam int BIN_WIDTH     = 8;     // 256 bins per segment
	localparam int BIN_NUM       = 1 << BIN_WIDTH;
	localparam int SEG_LOW_BIT   = 12;    // Leading one at bit 12 is r2 = 1/16
	localparam int LOOKUP_NUM    = SEGMENT_NUM * BIN_NUM;

	// Raw pair as accepted from upstream, ref_id at the MSB end
	typedef struct packed {
		logic        [PARTICLE_ID_WIDTH-1:0] ref_id;
		logic        [PARTICLE_ID_WIDTH-1:0] nbr_id;
		logic signed [DATA_WIDTH-1:0]        ref_x;
		logic signed [DATA_WIDTH-1:0]        ref_y;
		logic signed [DATA_WIDTH-1:0]        ref_z;
		logic signed [DATA_WIDTH-1:0]        nbr_x;
		logic signed [DATA_WIDTH-1:0]        nbr_y;
		logic signed [DATA_WIDTH-1:0]        nbr_z;
	} pair_in_t;

	// Displacement plus squared distance
	typedef struct packed {
		logic        [PARTICLE_ID_WIDTH-1:0] ref_id;
		logic        [PARTICLE_ID_WIDTH-1:0] nbr_id;
		logic signed [DATA_WIDTH-1:0]        dx;    // Neighbor minus reference
		logic signed [DATA_WIDTH-1:0]        dy;
		logic signed [DATA_WIDTH-1:0]        dz;
		logic        [DATA_WIDTH-1:0]        r2;    // Never negative
	} pair_delta_t;

	// Result returned downstream
	typedef struct packed {
		logic        [PARTICLE_ID_WIDTH-1:0] ref_id;
		logic        [PARTICLE_ID_WIDTH-1:0] nbr_id;
		logic signed [DATA_WIDTH-1:0]        force_x;
		logic signed [DATA_WIDTH-1:0]        force_y;
		logic signed [DATA_WIDTH-1:0]        force_z;
	} force_out_t;

	// Synthetic coefficient, falls off with segment and with bin
	// Segment 0 bin 0 gives 14.0 in Q16.16 terms of 1/16 steps
	function automatic logic signed [DATA_WIDTH-1:0] lj_coef(
		input logic [SEGMENT_WIDTH-1:0] seg,
		input logic [BIN_WIDTH-1:0]     bin
	);
		int base_val;
		int bin_val;
		base_val = (SEGMENT_NUM - int'(seg)) <<< 12;
		bin_val  = int'(bin) <<< 2;  // Small slope across a segment
		return DATA_WIDTH'(base_val - bin_val);
	endfunction

endpackage

`default_nettype wire

// ==== rtl/pair_fifo.sv ====
// Synchronous FIFO with head-of-queue read data; serves as input and output buffer of the LJ evaluator
`default_nettype none
`timescale 1ns/1ps

module pair_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 4
) (
	input  wire              clk,
	input  wire              rst,
	input  wire              wr_en,
	input  wire  [WIDTH-1:0] wr_data,
	input  wire              rd_en,
	output logic [WIDTH-1:0] rd_data,
	output logic             full,
	output logic             empty
);

	localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W  = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]  mem [DEPTH];  // Payload storage
	logic [ADDR_W-1:0] wr_ptr;
	logic [ADDR_W-1:0] rd_ptr;
	logic [CNT_W-1:0]  count;        // Occupancy
	logic              wr_ok;
	logic              rd_ok;

	assign full    = (count == CNT_W'(DEPTH));
	assign empty   = (count == '0);
	assign rd_data = mem[rd_ptr];    // Head shown without a read strobe

	// Full buffer still takes a write when the head leaves the same cycle
	assign wr_ok = wr_en && (!full || rd_en);
	assign rd_ok = rd_en && !empty;

	always_ff @(posedge clk)
	begin
		if (wr_ok)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (wr_ok)
				wr_ptr <= (wr_ptr == ADDR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap
			if (rd_ok)
				rd_ptr <= (rd_ptr == ADDR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({wr_ok, rd_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // Idle or pass-through
			endcase
		end
	end

	// Producer must respect full unless the head is leaving
	a_no_overflow: assert property (@(posedge clk) disable iff (rst) (wr_en && full) |-> rd_en)
		else $error("pair_fifo write while full");

	a_no_underflow: assert property (@(posedge clk) disable iff (rst) !(rd_en && empty))
		else $error("pair_fifo read while empty");

endmodule

`default_nettype wire

// ==== lj_pipe/lj_distance.sv ====
// Displacement, squared distance and cutoff filter; first two stages of the LJ pipeline
`default_nettype none
`timescale 1ns/1ps

module lj_distance import lj_pkg::*; #(
	parameter logic [DATA_WIDTH-1:0] CUTOFF_2 = 32'h0090_0000  // 144.0 in Q16.16
) (
	input  wire         clk,
	input  wire         rst,
	input  wire         in_valid,
	input  pair_in_t    pair,
	output logic        out_valid,
	output pair_delta_t delta,
	output logic        drop
);

	// Stage 1 registers
	logic                         s1_valid;
	logic [PARTICLE_ID_WIDTH-1:0] s1_ref_id;
	logic [PARTICLE_ID_WIDTH-1:0] s1_nbr_id;
	logic signed [DATA_WIDTH-1:0] s1_dx;
	logic signed [DATA_WIDTH-1:0] s1_dy;
	logic signed [DATA_WIDTH-1:0] s1_dz;

	// Stage 2 combinational terms
	logic signed [2*DATA_WIDTH-1:0] sq_x;   // Q32.32 squares
	logic signed [2*DATA_WIDTH-1:0] sq_y;
	logic signed [2*DATA_WIDTH-1:0] sq_z;
	logic        [2*DATA_WIDTH-1:0] r2_sum;
	logic        [DATA_WIDTH-1:0]   r2_next;

	always_ff @(posedge clk)
	begin
		s1_ref_id <= pair.ref_id;
		s1_nbr_id <= pair.nbr_id;
		s1_dx     <= pair.nbr_x - pair.ref_x;  // Neighbor minus reference
		s1_dy     <= pair.nbr_y - pair.ref_y;
		s1_dz     <= pair.nbr_z - pair.ref_z;
	end

	assign sq_x = s1_dx * s1_dx;
	assign sq_y = s1_dy * s1_dy;
	assign sq_z = s1_dz * s1_dz;

	// Back to Q16.16 before summing
	assign r2_sum  = (sq_x >>> FRAC_BITS) + (sq_y >>> FRAC_BITS) + (sq_z >>> FRAC_BITS);
	assign r2_next = r2_sum[DATA_WIDTH-1:0];

	always_ff @(posedge clk)
	begin
		delta.ref_id <= s1_ref_id;
		delta.nbr_id <= s1_nbr_id;
		delta.dx     <= s1_dx;
		delta.dy     <= s1_dy;
		delta.dz     <= s1_dz;
		delta.r2     <= r2_next;
	end

	// Valid chain, pair either passes the filter or is reported dropped
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			s1_valid  <= 1'b0;
			out_valid <= 1'b0;
			drop      <= 1'b0;
		end
		else
		begin
			s1_valid  <= in_valid;
			out_valid <= s1_valid && (r2_next < CUTOFF_2);
			drop      <= s1_valid && (r2_next >= CUTOFF_2);  // Feeds the credit count
		end
	end

	// Pass and drop are exclusive
	a_excl: assert property (@(posedge clk) disable iff (rst) !(out_valid && drop))
		else $error("lj_distance valid and drop together");

endmodule

`default_nettype wire

// ==== lj_pipe/lj_force_table.sv ====
// Segment and bin address from r2 and coefficient ROM read; middle two stages of the LJ pipeline
`default_nettype none
`timescale 1ns/1ps

module lj_force_table import lj_pkg::*; (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          in_valid,
	input  pair_delta_t                  delta_in,
	output logic                         out_valid,
	output pair_delta_t                  delta_out,
	output logic signed [DATA_WIDTH-1:0] coef
);

	localparam int POS_W = $clog2(DATA_WIDTH);

	logic signed [DATA_WIDTH-1:0] coef_rom [LOOKUP_NUM];  // {seg, bin} addressed

	logic [POS_W-1:0]         lead_pos;  // Leading one of r2
	logic [POS_W-1:0]         seg_raw;
	logic [DATA_WIDTH-1:0]    r2_shift;
	logic [SEGMENT_WIDTH-1:0] seg_next;
	logic [BIN_WIDTH-1:0]     bin_next;

	// Stage 1 registers
	logic                     s1_valid;
	pair_delta_t              s1_delta;
	logic [SEGMENT_WIDTH-1:0] s1_seg;
	logic [BIN_WIDTH-1:0]     s1_bin;

	// ROM contents fixed at elaboration
	initial
	begin
		for (int s = 0; s < SEGMENT_NUM; s++)
		begin
			for (int b = 0; b < BIN_NUM; b++)
				coef_rom[s*BIN_NUM + b] = lj_coef(SEGMENT_WIDTH'(s), BIN_WIDTH'(b));
		end
	end

	// Priority scan, highest set bit wins
	always_comb
	begin
		lead_pos = '0;
		for (int i = 0; i < DATA_WIDTH; i++)
		begin
			if (delta_in.r2[i])
				lead_pos = POS_W'(i);
		end
	end

	assign seg_raw  = lead_pos - POS_W'(SEG_LOW_BIT);
	assign r2_shift = delta_in.r2 >> (lead_pos - POS_W'(BIN_WIDTH));  // Bits below the leading one

	always_comb
	begin
		if (lead_pos < POS_W'(SEG_LOW_BIT))
		begin
			seg_next = '0;  // Below table range, includes r2 = 0
			bin_next = '0;
		end
		else
		begin
			if (seg_raw > POS_W'(SEGMENT_NUM - 1))
				seg_next = SEGMENT_WIDTH'(SEGMENT_NUM - 1);  // Clamp top segment
			else
				seg_next = seg_raw[SEGMENT_WIDTH-1:0];
			bin_next = r2_shift[BIN_WIDTH-1:0];
		end
	end

	always_ff @(posedge clk)
	begin
		s1_delta  <= delta_in;
		s1_seg    <= seg_next;
		s1_bin    <= bin_next;
		delta_out <= s1_delta;  // Pair rides alongside the ROM read
		coef      <= coef_rom[{s1_seg, s1_bin}];
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			s1_valid  <= 1'b0;
			out_valid <= 1'b0;
		end
		else
		begin
			s1_valid  <= in_valid;
			out_valid <= s1_valid;
		end
	end

	// Address must land inside the populated ROM
	a_seg_range: assert property (@(posedge clk) disable iff (rst)
		s1_valid |-> (s1_seg < SEGMENT_WIDTH'(SEGMENT_NUM)))
		else $error("lj_force_table segment out of range");

endmodule

`default_nettype wire

// ==== lj_pipe/lj_force_scale.sv ====
// Coefficient times displacement per axis with Q16.16 rescale; last stage of the LJ pipeline
`default_nettype none
`timescale 1ns/1ps

module lj_force_scale import lj_pkg::*; (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          in_valid,
	input  pair_delta_t                  delta,
	input  wire  signed [DATA_WIDTH-1:0] coef,
	output logic                         out_valid,
	output force_out_t                   pair_force
);

	// Full-width signed products, Q32.32
	logic signed [2*DATA_WIDTH-1:0] prod_x;
	logic signed [2*DATA_WIDTH-1:0] prod_y;
	logic signed [2*DATA_WIDTH-1:0] prod_z;
	logic signed [2*DATA_WIDTH-1:0] shr_x;
	logic signed [2*DATA_WIDTH-1:0] shr_y;
	logic signed [2*DATA_WIDTH-1:0] shr_z;

	assign prod_x = coef * delta.dx;
	assign prod_y = coef * delta.dy;
	assign prod_z = coef * delta.dz;

	// Arithmetic shift keeps the sign
	assign shr_x = prod_x >>> FRAC_BITS;
	assign shr_y = prod_y >>> FRAC_BITS;
	assign shr_z = prod_z >>> FRAC_BITS;

	always_ff @(posedge clk)
	begin
		pair_force.ref_id  <= delta.ref_id;  // IDs unchanged
		pair_force.nbr_id  <= delta.nbr_id;
		pair_force.force_x <= shr_x[DATA_WIDTH-1:0];  // Truncate to one word
		pair_force.force_y <= shr_y[DATA_WIDTH-1:0];
		pair_force.force_z <= shr_z[DATA_WIDTH-1:0];
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid;
	end

endmodule

`default_nettype wire

// ==== rtl/lj_eval_top.sv ====
// Top of the LJ pair evaluator with valid/ready buffers and credit-guarded output; instantiate as the DUT
`default_nettype none
`timescale 1ns/1ps

module lj_eval_top import lj_pkg::*; #(
	parameter logic [DATA_WIDTH-1:0] CUTOFF_2     = 32'h0090_0000,  // 144.0
	parameter int                    INPUT_DEPTH  = 4,
	parameter int                    OUTPUT_DEPTH = 32
) (
	input  wire        clk,
	input  wire        rst,
	input  wire        ivalid,     // Upstream side
	output logic       oready,
	input  pair_in_t   pair_in,
	output logic       ovalid,     // Downstream side
	input  wire        iready,
	output force_out_t force_out
);

	localparam int CREDIT_W = $clog2(OUTPUT_DEPTH + 1);

	// Input buffer
	logic        in_full;
	logic        in_empty;
	logic        in_pop;
	pair_in_t    in_head;

	// Pipeline links
	logic        dist_valid;
	logic        dist_drop;
	pair_delta_t dist_delta;
	logic        tab_valid;
	pair_delta_t tab_delta;
	logic signed [DATA_WIDTH-1:0] tab_coef;
	logic        scale_valid;
	force_out_t  scale_force;

	// Output buffer and credits
	logic                out_empty;
	logic                out_rd;
	logic [CREDIT_W-1:0] credit;  // Pairs in flight plus pairs buffered

	assign oready = !in_full;
	assign ovalid = !out_empty;
	assign out_rd = ovalid && iready;

	// Issue only with a guaranteed output slot
	assign in_pop = !in_empty && (credit < CREDIT_W'(OUTPUT_DEPTH));

	pair_fifo #(
		.WIDTH ($bits(pair_in_t)),
		.DEPTH (INPUT_DEPTH)
	) in_fifo_inst (
		.clk     (clk),
		.rst     (rst),
		.wr_en   (ivalid && oready),
		.wr_data (pair_in),
		.rd_en   (in_pop),
		.rd_data (in_head),
		.full    (in_full),
		.empty   (in_empty)
	);

	lj_distance #(
		.CUTOFF_2 (CUTOFF_2)
	) lj_distance_inst (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_pop),
		.pair      (in_head),
		.out_valid (dist_valid),
		.delta     (dist_delta),
		.drop      (dist_drop)
	);

	lj_force_table lj_force_table_inst (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (dist_valid),
		.delta_in  (dist_delta),
		.out_valid (tab_valid),
		.delta_out (tab_delta),
		.coef      (tab_coef)
	);

	lj_force_scale lj_force_scale_inst (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (tab_valid),
		.delta      (tab_delta),
		.coef       (tab_coef),
		.out_valid  (scale_valid),
		.pair_force (scale_force)
	);

	// Never stalls; credits keep a slot free
	pair_fifo #(
		.WIDTH ($bits(force_out_t)),
		.DEPTH (OUTPUT_DEPTH)
	) out_fifo_inst (
		.clk     (clk),
		.rst     (rst),
		.wr_en   (scale_valid),
		.wr_data (scale_force),
		.rd_en   (out_rd),
		.rd_data (force_out),
		.full    (),
		.empty   (out_empty)
	);

	// Up on issue, down on consume or filter drop
	always_ff @(posedge clk)
	begin
		if (rst)
			credit <= '0;
		else
			credit <= credit + CREDIT_W'(in_pop) - CREDIT_W'(out_rd) - CREDIT_W'(dist_drop);
	end

	a_credit_max: assert property (@(posedge clk) disable iff (rst)
		credit <= CREDIT_W'(OUTPUT_DEPTH))
		else $error("lj_eval_top credit overrun");

endmodule

`default_nettype wire

// ==== tests/lj_eval_tb.sv ====
// Random-stimulus testbench for the LJ pair evaluator; compares every consumed result with a model
`default_nettype none
`timescale 1ns/1ps

module lj_eval_tb import lj_pkg::*; ();

	localparam int PAIR_NUM       = 400;
	localparam int TIMEOUT_CYCLES = PAIR_NUM * 30 + 200;
	localparam int STALL_AT       = 150;  // Pairs sent before iready is held low
	localparam int STALL_CYCLES   = 200;
	localparam int DRAIN_CYCLES   = 20;
	localparam int CHECK_W        = $bits(force_out_t);
	localparam logic [DATA_WIDTH-1:0] CUTOFF_2   = 32'd144 << FRAC_BITS;
	localparam logic [DATA_WIDTH-1:0] COORD_MASK = 32'h000F_FFFF;  // [0, 16)

	logic       clk;
	logic       rst;
	logic       ivalid;
	logic       oready;
	pair_in_t   pair_in;
	logic       ovalid;
	logic       iready;
	force_out_t force_out;

	int         seed;
	int         sent;        // Pairs accepted by the DUT
	int         stall_left;
	logic       stall_started;
	logic       saw_oready_low;
	int         cycle_count = 0;
	pair_in_t   cur_pair;
	force_out_t exp_force;
	force_out_t expected_q [$];  // Scoreboard in acceptance order

	lj_eval_top lj_eval_top_inst (
		.clk       (clk),
		.rst       (rst),
		.ivalid    (ivalid),
		.oready    (oready),
		.pair_in   (pair_in),
		.ovalid    (ovalid),
		.iready    (iready),
		.force_out (force_out)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;  // 4 ns period
	end

	// Hard stop if results never arrive
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles, results still missing", cycle_count);
			$display("Simulation FAILED");
			$fatal(1, "run did not finish in time");
		end
	end

	task automatic report_failure(input string msg);
		$display("error at %0t: %s", $time, msg);
		$display("Simulation FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_value(input logic [CHECK_W-1:0] actual,
		input logic [CHECK_W-1:0] expected, input string what);
		if (actual !== expected)
		begin
			$display("mismatch at %0t: %s got %h expected %h", $time, what, actual, expected);
			$display("Simulation FAILED");
			$fatal(1, "stopping at first error");
		end
	endtask

	// Reference rules: displacement, r2 filter, segment/bin lookup, scale
	function automatic logic model_force(input pair_in_t p, output force_out_t f);
		logic signed [DATA_WIDTH-1:0]   d [3];
		logic signed [DATA_WIDTH-1:0]   fv [3];
		logic signed [2*DATA_WIDTH-1:0] sq;
		logic signed [2*DATA_WIDTH-1:0] prod;
		logic        [2*DATA_WIDTH-1:0] acc;
		logic        [DATA_WIDTH-1:0]   r2;
		logic        [SEGMENT_WIDTH-1:0] seg;
		logic        [BIN_WIDTH-1:0]    bin;
		logic signed [DATA_WIDTH-1:0]   c;
		int lead;
		int k;
		f = '0;
		d[0] = p.nbr_x - p.ref_x;
		d[1] = p.nbr_y - p.ref_y;
		d[2] = p.nbr_z - p.ref_z;
		acc = '0;
		for (k = 0; k < 3; k++)
		begin
			sq  = (2*DATA_WIDTH)'(d[k]) * (2*DATA_WIDTH)'(d[k]);
			acc = acc + (sq >>> FRAC_BITS);  // Each square back to Q16.16
		end
		r2 = acc[DATA_WIDTH-1:0];
		if (r2 >= CUTOFF_2)
			return 1'b0;  // Filtered, never reaches the output
		lead = -1;
		for (k = 0; k < DATA_WIDTH; k++)
		begin
			if (r2[k])
				lead = k;
		end
		if (lead < SEG_LOW_BIT)
		begin
			seg = '0;  // Below the table, includes coincident points
			bin = '0;
		end
		else
		begin
			seg = (lead - SEG_LOW_BIT > SEGMENT_NUM - 1) ? SEGMENT_WIDTH'(SEGMENT_NUM - 1)
				: SEGMENT_WIDTH'(lead - SEG_LOW_BIT);
			bin = BIN_WIDTH'(r2 >> (lead - BIN_WIDTH));  // Eight bits under the leading one
		end
		c = lj_coef(seg, bin);
		for (k = 0; k < 3; k++)
		begin
			prod  = (2*DATA_WIDTH)'(c) * (2*DATA_WIDTH)'(d[k]);
			fv[k] = DATA_WIDTH'(prod >>> FRAC_BITS);
		end
		f.ref_id  = p.ref_id;
		f.nbr_id  = p.nbr_id;
		f.force_x = fv[0];
		f.force_y = fv[1];
		f.force_z = fv[2];
		return 1'b1;
	endfunction

	// Mix of uniform, far and near-coincident pairs
	task automatic next_pair(output pair_in_t p);
		int kind;
		logic [DATA_WIDTH-1:0] off_mask;
		p = '0;
		kind = int'(($random(seed) & 32'h7fff_ffff) % 6);
		p.ref_id = PARTICLE_ID_WIDTH'($random(seed));
		p.nbr_id = PARTICLE_ID_WIDTH'($random(seed));
		p.ref_x = $random(seed) & COORD_MASK;
		p.ref_y = $random(seed) & COORD_MASK;
		p.ref_z = $random(seed) & COORD_MASK;
		p.nbr_x = $random(seed) & COORD_MASK;
		p.nbr_y = $random(seed) & COORD_MASK;
		p.nbr_z = $random(seed) & COORD_MASK;
		if (kind < 2)
		begin
			p.ref_x = $random(seed) & 32'h0001_FFFF;
			p.nbr_x = p.ref_x + (32'd13 << FRAC_BITS);  // dx of 13, beyond cutoff
		end
		else if (kind == 2)
		begin
			off_mask = ($random(seed) & 1) ? 32'h0000_03FF : 32'h0;  // Zero means same point
			p.ref_x = p.ref_x | 32'h400;
			p.ref_y = p.ref_y | 32'h400;
			p.ref_z = p.ref_z | 32'h400;
			p.nbr_x = p.ref_x - ($random(seed) & off_mask);
			p.nbr_y = p.ref_y - ($random(seed) & off_mask);
			p.nbr_z = p.ref_z - ($random(seed) & off_mask);
		end
	endtask

	initial
	begin
		seed = 73133;
		rst = 1'b1;
		ivalid = 1'b0;
		iready = 1'b0;
		pair_in = '0;
		sent = 0;
		stall_left = 0;
		stall_started = 1'b0;
		saw_oready_low = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_value(CHECK_W'(ovalid), CHECK_W'(1'b0), "ovalid after reset");
		check_value(CHECK_W'(oready), CHECK_W'(1'b1), "oready after reset");
		next_pair(cur_pair);

		// All decisions at the falling edge, outputs are settled here
		while (sent < PAIR_NUM || expected_q.size() != 0)
		begin
			if (sent == STALL_AT && !stall_started)
			begin
				stall_started = 1'b1;
				stall_left = STALL_CYCLES;
			end
			if (stall_left > 0)
			begin
				iready = 1'b0;  // Long back-pressure stretch
				stall_left--;
				if (!oready)
					saw_oready_low = 1'b1;
			end
			else
				iready = (($random(seed) & 7) < 6);
			ivalid = (sent < PAIR_NUM) && (($random(seed) & 3) != 0);
			pair_in = cur_pair;
			if (ivalid && oready)
			begin
				if (model_force(cur_pair, exp_force))
					expected_q.push_back(exp_force);
				sent++;
				next_pair(cur_pair);
			end
			if (ovalid && iready)
			begin
				if (expected_q.size() == 0)
					report_failure("result appeared with no pending accepted pair");
				else
					check_value(CHECK_W'(force_out), CHECK_W'(expected_q.pop_front()), "force_out");
			end
			@(negedge clk);
		end

		// Nothing more may come out once the scoreboard is empty
		ivalid = 1'b0;
		iready = 1'b1;
		repeat (DRAIN_CYCLES)
		begin
			@(negedge clk);
			if (ovalid)
				report_failure("extra result after all expected results arrived");
		end
		check_value(CHECK_W'(saw_oready_low), CHECK_W'(1'b1), "oready low during stall");

		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== lj_eval_top.f ====
common/lj_pkg.sv
rtl/pair_fifo.sv
lj_pipe/lj_distance.sv
lj_pipe/lj_force_table.sv
lj_pipe/lj_force_scale.sv
rtl/lj_eval_top.sv
tests/lj_eval_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module lj_eval_tb \
		-f lj_eval_top.f -Mdir obj_dir
	out=$$(./obj_dir/Vlj_eval_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
